/* core_pkg.sv */
// shared types for the register rename block
// register counts, index types and the port structs used by every module
package core_pkg;

    // ------------------------------------------------------------
    // architecture sizes
    // ------------------------------------------------------------

    // architectural and physical register counts
    localparam int AR_COUNT     = 32;
    localparam int PR_COUNT     = 64;
    localparam int LOG_AR_COUNT = 5;
    localparam int LOG_PR_COUNT = 6;

    // instructions renamed per cycle
    localparam int RENAME_WIDTH = 4;

    // registers not held by the map after reset
    localparam int FREE_COUNT   = PR_COUNT - AR_COUNT;

    // register index types
    typedef logic [LOG_AR_COUNT-1:0] ar_t;
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // ------------------------------------------------------------
    // port structs
    // ------------------------------------------------------------

    // one instruction slot from dispatch
    typedef struct packed {
        logic valid;
        ar_t  src_a;
        ar_t  src_b;
        ar_t  dest;
        logic writes_dest;
    } rename_req_t;

    // one renamed slot back to dispatch
    typedef struct packed {
        logic valid;
        pr_t  src_a_pr;
        pr_t  src_b_pr;
        logic src_a_ready;
        logic src_b_ready;
        pr_t  dest_pr;
        pr_t  old_dest_pr;
    } rename_resp_t;

    // writeback or commit of one physical register
    typedef struct packed {
        logic valid;
        pr_t  pr;
    } reg_update_t;

endpackage

/* free_list.sv */
// free list of physical registers
// circular FIFO, up to four pops at the head and four pushes at the tail per cycle
// holds AR_COUNT to PR_COUNT-1 after reset
`timescale 1ns/1ns

module free_list import core_pkg::*; (
    input  logic                                    CLK,
    input  logic                                    nRST,

    // registers taken by the rename stage this cycle
    input  logic        [$clog2(RENAME_WIDTH+1)-1:0] pop_count,

    // registers returned by commit
    input  reg_update_t [RENAME_WIDTH-1:0]          push_ports,

    // next four free registers and the held count
    output pr_t         [RENAME_WIDTH-1:0]          head_pr,
    output logic        [LOG_PR_COUNT-1:0]          free_count
);

    // pointer width, FREE_COUNT is a power of two so pointers wrap by themselves
    localparam int PTR_W = $clog2(FREE_COUNT);
    localparam int CNT_W = $clog2(RENAME_WIDTH + 1);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    pr_t                     fifo_q [FREE_COUNT];
    pr_t                     fifo_d [FREE_COUNT];
    logic [PTR_W-1:0]        head_q;
    logic [PTR_W-1:0]        head_d;
    logic [PTR_W-1:0]        tail_q;
    logic [PTR_W-1:0]        tail_d;
    logic [LOG_PR_COUNT-1:0] count_q;
    logic [LOG_PR_COUNT-1:0] count_d;

    // valid pushes this cycle
    logic [CNT_W-1:0]        push_count;

    // ------------------------------------------------------------
    // head read
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            head_pr[i] = fifo_q[head_q + PTR_W'(i)];
        end
    end

    // held count only, this cycle's pushes show up next cycle
    assign free_count = count_q;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------

    always_comb begin
        fifo_d     = fifo_q;
        tail_d     = tail_q;
        push_count = '0;
        // pack valid pushes at the tail in slot order
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (push_ports[i].valid) begin
                fifo_d[tail_d] = push_ports[i].pr;
                tail_d         = tail_d + PTR_W'(1);
                push_count     = push_count + CNT_W'(1);
            end
        end
        // pops just move the head
        head_d  = head_q + PTR_W'(pop_count);
        count_d = count_q - LOG_PR_COUNT'(pop_count) + LOG_PR_COUNT'(push_count);
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            // ascending fill with the registers outside the identity map
            for (int i = 0; i < FREE_COUNT; i++) begin
                fifo_q[i] <= pr_t'(AR_COUNT + i);
            end
            head_q  <= '0;
            // full, so tail wraps onto head
            tail_q  <= '0;
            count_q <= LOG_PR_COUNT'(FREE_COUNT);
        end else begin
            fifo_q  <= fifo_d;
            head_q  <= head_d;
            tail_q  <= tail_d;
            count_q <= count_d;
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // stall in the rename stage must hold back any group it can't fill
    pop_within_count: assert property (@(posedge CLK) disable iff (!nRST)
        LOG_PR_COUNT'(pop_count) <= count_q)
        else $error("free list pop of %0d with %0d free", pop_count, count_q);

    // commits never return more registers than were handed out
    count_within_capacity: assert property (@(posedge CLK) disable iff (!nRST)
        count_q <= LOG_PR_COUNT'(FREE_COUNT))
        else $error("free list count %0d above capacity", count_q);

endmodule

/* map_table.sv */
// register map table
// architectural to physical mapping with 8 source lookups and 4 dest lookups
// lookups see the registered map, writes land at the edge in slot order
`timescale 1ns/1ns

module map_table import core_pkg::*; (
    input  logic                          CLK,
    input  logic                          nRST,

    // source lookups, two per slot
    input  ar_t  [2*RENAME_WIDTH-1:0]     src_ar,
    output pr_t  [2*RENAME_WIDTH-1:0]     src_pr,

    // destination lookups for the old mapping
    input  ar_t  [RENAME_WIDTH-1:0]       dest_ar,
    output pr_t  [RENAME_WIDTH-1:0]       dest_old_pr,

    // new mappings
    input  logic [RENAME_WIDTH-1:0]       write_en,
    input  pr_t  [RENAME_WIDTH-1:0]       write_pr
);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    pr_t map_q [AR_COUNT];
    pr_t map_d [AR_COUNT];

    // write target already held by some architectural register
    logic [RENAME_WIDTH-1:0] write_mapped;

    // ------------------------------------------------------------
    // lookups
    // ------------------------------------------------------------

    // registered mapping only
    // same-group forwarding is done by the rename stage
    always_comb begin
        for (int r = 0; r < 2 * RENAME_WIDTH; r++) begin
            src_pr[r] = map_q[src_ar[r]];
        end
        for (int d = 0; d < RENAME_WIDTH; d++) begin
            dest_old_pr[d] = map_q[dest_ar[d]];
        end
    end

    // ------------------------------------------------------------
    // writes
    // ------------------------------------------------------------

    // slot order, later slot overwrites an earlier one
    always_comb begin
        map_d = map_q;
        for (int w = 0; w < RENAME_WIDTH; w++) begin
            if (write_en[w]) begin
                map_d[dest_ar[w]] = write_pr[w];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            // identity mapping
            for (int a = 0; a < AR_COUNT; a++) begin
                map_q[a] <= pr_t'(a);
            end
        end else begin
            map_q <= map_d;
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    always_comb begin
        for (int w = 0; w < RENAME_WIDTH; w++) begin
            write_mapped[w] = 1'b0;
            for (int a = 0; a < AR_COUNT; a++) begin
                if (map_q[a] == write_pr[w]) begin
                    write_mapped[w] = 1'b1;
                end
            end
        end
    end

    // new mappings come from the free list head
    // a register still held by the map is not free until its commit
    for (genvar g = 0; g < RENAME_WIDTH; g++) begin : g_write_chk
        write_is_free: assert property (@(posedge CLK) disable iff (!nRST)
            write_en[g] |-> !write_mapped[g])
            else $error("map write %0d takes mapped register %0d", g, write_pr[g]);
    end

endmodule

/* ready_table.sv */
// physical register ready table
// one ready bit per physical register, 8 read ports, 4 set and 4 clear ports
// reads see this cycle's sets and clears
`timescale 1ns/1ns

module ready_table import core_pkg::*; (
    input  logic                               CLK,
    input  logic                               nRST,

    // source reads
    input  pr_t         [2*RENAME_WIDTH-1:0]   read_pr,
    output logic        [2*RENAME_WIDTH-1:0]   read_ready,

    // writebacks
    input  reg_update_t [RENAME_WIDTH-1:0]     set_ports,

    // fresh allocations
    input  reg_update_t [RENAME_WIDTH-1:0]     clear_ports
);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    logic [PR_COUNT-1:0] ready_q;
    logic [PR_COUNT-1:0] ready_d;

    // same register set and cleared in one cycle
    logic                set_clear_clash;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------

    always_comb begin
        ready_d = ready_q;
        // sets first
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            if (set_ports[s].valid) begin
                ready_d[set_ports[s].pr] = 1'b1;
            end
        end
        // then clears, so a clear wins
        for (int c = 0; c < RENAME_WIDTH; c++) begin
            if (clear_ports[c].valid) begin
                ready_d[clear_ports[c].pr] = 1'b0;
            end
        end
    end

    // reads bypass from next state
    always_comb begin
        for (int r = 0; r < 2 * RENAME_WIDTH; r++) begin
            read_ready[r] = ready_d[read_pr[r]];
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            // registers behind the identity map start ready
            for (int p = 0; p < PR_COUNT; p++) begin
                ready_q[p] <= (p < AR_COUNT);
            end
        end else begin
            ready_q <= ready_d;
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    always_comb begin
        set_clear_clash = 1'b0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            for (int c = 0; c < RENAME_WIDTH; c++) begin
                if (set_ports[s].valid && clear_ports[c].valid &&
                    set_ports[s].pr == clear_ports[c].pr) begin
                    set_clear_clash = 1'b1;
                end
            end
        end
    end

    // a register being allocated has no result in flight from writeback
    no_set_on_alloc: assert property (@(posedge CLK) disable iff (!nRST)
        !set_clear_clash)
        else $error("ready table set and clear to the same register");

endmodule

/* rename_stage.sv */
// register rename stage
// renames up to four instructions per cycle, resolves same-group dependencies
// stalls the whole group when the free list is short
`timescale 1ns/1ns

module rename_stage import core_pkg::*; (
    input  logic                                CLK,
    input  logic                                nRST,

    // dispatch side
    input  rename_req_t  [RENAME_WIDTH-1:0]     req,
    output rename_resp_t [RENAME_WIDTH-1:0]     resp,
    output logic                                stall,

    // writeback and commit
    input  reg_update_t  [RENAME_WIDTH-1:0]     writeback,
    input  reg_update_t  [RENAME_WIDTH-1:0]     commit
);

    localparam int CNT_W = $clog2(RENAME_WIDTH + 1);
    localparam int IDX_W = $clog2(RENAME_WIDTH);

    // ------------------------------------------------------------
    // signals
    // ------------------------------------------------------------

    // table lookups
    ar_t         [2*RENAME_WIDTH-1:0] src_ar;
    pr_t         [2*RENAME_WIDTH-1:0] src_pr;
    logic        [2*RENAME_WIDTH-1:0] src_ready;
    ar_t         [RENAME_WIDTH-1:0]   dest_ar;
    pr_t         [RENAME_WIDTH-1:0]   dest_old_pr;

    // allocation
    logic        [RENAME_WIDTH-1:0]   writes;
    logic        [RENAME_WIDTH-1:0]   write_en;
    pr_t         [RENAME_WIDTH-1:0]   alloc_pr;
    pr_t         [RENAME_WIDTH-1:0]   head_pr;
    logic        [CNT_W-1:0]          need_count;
    logic        [CNT_W-1:0]          run_count;
    logic        [CNT_W-1:0]          pop_count;
    logic        [LOG_PR_COUNT-1:0]   free_count;
    reg_update_t [RENAME_WIDTH-1:0]   clear_ports;

    // ------------------------------------------------------------
    // allocation and stall
    // ------------------------------------------------------------

    // head entries go to writing slots in slot order
    always_comb begin
        run_count = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            writes[i]   = req[i].valid & req[i].writes_dest;
            alloc_pr[i] = head_pr[IDX_W'(run_count)];
            run_count   = run_count + CNT_W'(writes[i]);
        end
        need_count = run_count;
    end

    // whole group waits, held count only
    assign stall     = nRST & (LOG_PR_COUNT'(need_count) > free_count);
    assign pop_count = stall ? '0 : need_count;

    // table ports
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            src_ar[2*i]          = req[i].src_a;
            src_ar[2*i+1]        = req[i].src_b;
            dest_ar[i]           = req[i].dest;
            write_en[i]          = writes[i] & ~stall;
            // new register is not ready until its writeback
            clear_ports[i].valid = write_en[i];
            clear_ports[i].pr    = alloc_pr[i];
        end
    end

    // ------------------------------------------------------------
    // responses
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            resp[i].valid       = req[i].valid & ~stall & nRST;
            resp[i].src_a_pr    = src_pr[2*i];
            resp[i].src_a_ready = src_ready[2*i];
            resp[i].src_b_pr    = src_pr[2*i+1];
            resp[i].src_b_ready = src_ready[2*i+1];
            resp[i].dest_pr     = alloc_pr[i];
            resp[i].old_dest_pr = dest_old_pr[i];
            // earlier slots in ascending order, nearest one lands last
            for (int j = 0; j < i; j++) begin
                if (writes[j] && req[j].dest == req[i].src_a) begin
                    resp[i].src_a_pr    = alloc_pr[j];
                    resp[i].src_a_ready = 1'b0;
                end
                if (writes[j] && req[j].dest == req[i].src_b) begin
                    resp[i].src_b_pr    = alloc_pr[j];
                    resp[i].src_b_ready = 1'b0;
                end
                if (writes[j] && req[j].dest == req[i].dest) begin
                    resp[i].old_dest_pr = alloc_pr[j];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // tables
    // ------------------------------------------------------------

    ready_table u_ready_table (
        .CLK         (CLK),
        .nRST        (nRST),
        .read_pr     (src_pr),
        .read_ready  (src_ready),
        .set_ports   (writeback),
        .clear_ports (clear_ports)
    );

    map_table u_map_table (
        .CLK         (CLK),
        .nRST        (nRST),
        .src_ar      (src_ar),
        .src_pr      (src_pr),
        .dest_ar     (dest_ar),
        .dest_old_pr (dest_old_pr),
        .write_en    (write_en),
        .write_pr    (alloc_pr)
    );

    free_list u_free_list (
        .CLK         (CLK),
        .nRST        (nRST),
        .pop_count   (pop_count),
        .push_ports  (commit),
        .head_pr     (head_pr),
        .free_count  (free_count)
    );

endmodule

/* rename_tb_tasks.svh */
// directed tests for the rename stage
// each test drives whole groups, the model checks every response

// fixed writing group, sources and destinations from base up
task automatic fixed_group(input int base);
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        req[i].valid       = 1'b1;
        req[i].src_a       = ar_t'(base + i);
        req[i].src_b       = ar_t'(base + RENAME_WIDTH - 1 - i);
        req[i].dest        = ar_t'(base + i);
        req[i].writes_dest = 1'b1;
    end
endtask

// all 32 registers read once, identity and ready
task automatic test_reset_state();
    for (int n = 0; n < 4; n++) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            req[i].valid = 1'b1;
            req[i].src_a = ar_t'(8 * n + 2 * i);
            req[i].src_b = ar_t'(8 * n + 2 * i + 1);
            req[i].dest  = ar_t'(i);
        end
        rename_cycle("reset_state");
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            check_field("reset_state", i, "identity", 8 * n + 2 * i, int'(last_resp[i].src_a_pr));
            check_field("reset_state", i, "ready", 1, int'(last_resp[i].src_b_ready));
        end
    end
endtask

// r1..r4 get 32..35, then read back not ready
task automatic test_allocation();
    fixed_group(1);
    rename_cycle("allocation");
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        check_field("allocation", i, "new pr", AR_COUNT + i, int'(last_resp[i].dest_pr));
        check_field("allocation", i, "old pr", i + 1, int'(last_resp[i].old_dest_pr));
        req[i].valid = 1'b1;
        req[i].src_a = ar_t'(i + 1);
    end
    rename_cycle("allocation_read");
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        check_field("allocation_read", i, "pr", AR_COUNT + i, int'(last_resp[i].src_a_pr));
        check_field("allocation_read", i, "ready", 0, int'(last_resp[i].src_a_ready));
    end
endtask

// 32 and 33 written back, ready in the same cycle and after
task automatic test_writeback();
    for (int n = 0; n < 2; n++) begin
        for (int i = 0; i < 3; i++) begin
            req[i].valid = 1'b1;
            req[i].src_a = ar_t'(i + 1);
        end
        if (n == 0) begin
            writeback[0] = '{valid: 1'b1, pr: pr_t'(AR_COUNT)};
            writeback[1] = '{valid: 1'b1, pr: pr_t'(AR_COUNT + 1)};
        end
        rename_cycle("writeback");
        check_field("writeback", 0, "ready", 1, int'(last_resp[0].src_a_ready));
        check_field("writeback", 1, "ready", 1, int'(last_resp[1].src_a_ready));
        // 34 still in flight
        check_field("writeback", 2, "ready", 0, int'(last_resp[2].src_a_ready));
    end
endtask

// slot 0 and slot 2 both write r5, slots 1 and 3 read it
task automatic test_same_group();
    req[0] = '{valid: 1'b1, src_a: 5'd6, src_b: 5'd7, dest: 5'd5, writes_dest: 1'b1};
    req[1] = '{valid: 1'b1, src_a: 5'd5, src_b: 5'd0, dest: 5'd0, writes_dest: 1'b0};
    req[2] = '{valid: 1'b1, src_a: 5'd5, src_b: 5'd6, dest: 5'd5, writes_dest: 1'b1};
    req[3] = '{valid: 1'b1, src_a: 5'd0, src_b: 5'd5, dest: 5'd0, writes_dest: 1'b0};
    rename_cycle("same_group");
    check_field("same_group", 1, "src_a_pr", 36, int'(last_resp[1].src_a_pr));
    check_field("same_group", 2, "old pr", 36, int'(last_resp[2].old_dest_pr));
    check_field("same_group", 3, "src_b_pr", 37, int'(last_resp[3].src_b_pr));
    check_field("same_group", 3, "src_b_ready", 0, int'(last_resp[3].src_b_ready));
    // later slot owns r5
    req[0].valid = 1'b1;
    req[0].src_a = 5'd5;
    rename_cycle("same_group_read");
    check_field("same_group_read", 0, "src_a_pr", 37, int'(last_resp[0].src_a_pr));
endtask

// drain the free list, stall, commit, recover in FIFO order
task automatic test_stall_recovery();
    int  free_left;
    pr_t freed [RENAME_WIDTH];
    while (model_free.size() >= RENAME_WIDTH) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            req[i].valid       = 1'b1;
            req[i].src_a       = ar_t'($urandom_range(AR_COUNT - 1));
            req[i].src_b       = ar_t'($urandom_range(AR_COUNT - 1));
            req[i].dest        = ar_t'($urandom_range(AR_COUNT - 1));
            req[i].writes_dest = 1'b1;
        end
        rename_cycle("fill");
    end
    free_left = model_free.size();
    fixed_group(8);
    rename_cycle("stall");
    check_field("stall", -1, "stall", 1, int'(last_stall));
    // commits count from the next cycle
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        freed[i]  = retired[i];
        commit[i] = '{valid: 1'b1, pr: freed[i]};
    end
    fixed_group(8);
    rename_cycle("stall_commit");
    check_field("stall_commit", -1, "stall", 1, int'(last_stall));
    fixed_group(8);
    rename_cycle("recover");
    check_field("recover", -1, "stall", 0, int'(last_stall));
    check_field("recover", 0, "new pr", PR_COUNT - free_left, int'(last_resp[0].dest_pr));
    check_field("recover", free_left, "new pr", int'(freed[0]),
                int'(last_resp[free_left].dest_pr));
    // new mappings visible
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        req[i].valid = 1'b1;
        req[i].src_a = ar_t'(8 + i);
    end
    rename_cycle("after_recover");
endtask

/* rename_tb.sv */
// testbench for the register rename stage
// acts as dispatch, writeback and commit, checks each group against a small model
`timescale 1ns/1ns

module rename_tb import core_pkg::*; ();

    // tests take about 25 cycles after reset, so 400 leaves a wide margin
    localparam int TIMEOUT_CYCLES = 400;

    // ------------------------------------------------------------
    // DUT
    // ------------------------------------------------------------

    logic                            CLK;
    logic                            nRST;
    rename_req_t  [RENAME_WIDTH-1:0] req;
    rename_resp_t [RENAME_WIDTH-1:0] resp;
    logic                            stall;
    reg_update_t  [RENAME_WIDTH-1:0] writeback;
    reg_update_t  [RENAME_WIDTH-1:0] commit;

    rename_stage dut0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .resp      (resp),
        .stall     (stall),
        .writeback (writeback),
        .commit    (commit)
    );

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    pr_t                             model_map [AR_COUNT];
    logic [PR_COUNT-1:0]             model_ready;
    pr_t                             model_free [$];
    // old mappings of renamed slots, oldest first
    pr_t                             retired [$];
    // last checked group, for the tests' own checks
    rename_resp_t [RENAME_WIDTH-1:0] last_resp;
    logic                            last_stall;
    int                              cycles = 0;

    always #20 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Something failed");
            $fatal(1, "timeout, no end of test after %0d cycles", cycles);
        end
    end

    task automatic check_field(input string test, input int slot, input string field,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Fail %s slot %0d %s expected %0d actual %0d",
                     test, slot, field, expected, actual);
            $display("Something failed");
            $fatal(1, "check failed in %s", test);
        end
    endtask

    task automatic drive_idle();
        req       = '0;
        writeback = '0;
        commit    = '0;
    endtask

    // identity map, low registers ready, the rest free in ascending order
    task automatic reset_model();
        model_free.delete();
        retired.delete();
        for (int a = 0; a < AR_COUNT; a++) begin
            model_map[a] = pr_t'(a);
        end
        for (int p = 0; p < PR_COUNT; p++) begin
            model_ready[p] = (p < AR_COUNT);
            if (p >= AR_COUNT) begin
                model_free.push_back(pr_t'(p));
            end
        end
    endtask

    // nearest earlier slot of the group writing ar, -1 if none
    function automatic int nearest_writer(input int slot, input ar_t ar);
        for (int j = slot - 1; j >= 0; j--) begin
            if (req[j].valid && req[j].writes_dest && req[j].dest == ar) begin
                return j;
            end
        end
        return -1;
    endfunction

    `include "rename_tb_tasks.svh"

    // ------------------------------------------------------------
    // one group, inputs already driven 5 ns after the edge
    // ------------------------------------------------------------

    task automatic rename_cycle(input string test);
        logic [RENAME_WIDTH-1:0]         writes;
        pr_t                             alloc [RENAME_WIDTH];
        logic [PR_COUNT-1:0]             ready_next;
        rename_resp_t [RENAME_WIDTH-1:0] exp;
        logic                            exp_stall;
        int                              need;
        int                              w;
        need = 0;
        // k-th writing slot takes k-th free register
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            writes[i] = req[i].valid & req[i].writes_dest;
            alloc[i]  = '0;
            if (writes[i]) begin
                if (need < model_free.size()) begin
                    alloc[i] = model_free[need];
                end
                need++;
            end
        end
        // only registers already held count
        exp_stall  = need > model_free.size();
        ready_next = model_ready;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (writeback[i].valid) begin
                ready_next[writeback[i].pr] = 1'b1;
            end
        end
        // allocation clears win over writeback
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (writes[i] && !exp_stall) begin
                ready_next[alloc[i]] = 1'b0;
            end
        end
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            exp[i].valid       = req[i].valid & ~exp_stall;
            exp[i].dest_pr     = alloc[i];
            exp[i].src_a_pr    = model_map[req[i].src_a];
            exp[i].src_a_ready = ready_next[exp[i].src_a_pr];
            exp[i].src_b_pr    = model_map[req[i].src_b];
            exp[i].src_b_ready = ready_next[exp[i].src_b_pr];
            exp[i].old_dest_pr = model_map[req[i].dest];
            w = nearest_writer(i, req[i].src_a);
            if (w >= 0) begin
                exp[i].src_a_pr    = alloc[w];
                exp[i].src_a_ready = 1'b0;
            end
            w = nearest_writer(i, req[i].src_b);
            if (w >= 0) begin
                exp[i].src_b_pr    = alloc[w];
                exp[i].src_b_ready = 1'b0;
            end
            w = nearest_writer(i, req[i].dest);
            if (w >= 0) begin
                exp[i].old_dest_pr = alloc[w];
            end
        end
        // sample well before the next edge
        #20;
        check_field(test, -1, "stall", int'(exp_stall), int'(stall));
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            check_field(test, i, "valid", int'(exp[i].valid), int'(resp[i].valid));
            if (exp[i].valid) begin
                check_field(test, i, "src_a_pr", int'(exp[i].src_a_pr), int'(resp[i].src_a_pr));
                check_field(test, i, "src_a_ready", int'(exp[i].src_a_ready),
                            int'(resp[i].src_a_ready));
                check_field(test, i, "src_b_pr", int'(exp[i].src_b_pr), int'(resp[i].src_b_pr));
                check_field(test, i, "src_b_ready", int'(exp[i].src_b_ready),
                            int'(resp[i].src_b_ready));
                check_field(test, i, "old_dest_pr", int'(exp[i].old_dest_pr),
                            int'(resp[i].old_dest_pr));
                if (writes[i]) begin
                    check_field(test, i, "dest_pr", int'(exp[i].dest_pr), int'(resp[i].dest_pr));
                end
            end
        end
        last_resp   = resp;
        last_stall  = stall;
        // model update for the coming edge
        model_ready = ready_next;
        if (!exp_stall) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (writes[i]) begin
                    retired.push_back(model_map[req[i].dest]);
                    model_map[req[i].dest] = alloc[i];
                end
            end
            for (int n = 0; n < need; n++) begin
                void'(model_free.pop_front());
            end
        end
        // commits land behind the remaining free registers
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (commit[i].valid) begin
                model_free.push_back(commit[i].pr);
            end
        end
        @(posedge CLK);
        #5;
        drive_idle();
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(28));
        CLK  = 1'b0;
        nRST = 1'b0;
        drive_idle();
        reset_model();
        repeat (4) @(posedge CLK);
        #5;
        nRST = 1'b1;
        test_reset_state();
        test_allocation();
        test_writeback();
        test_same_group();
        test_stall_recovery();
        $display("Everything OK");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim

/* verilog.f */
+incdir+.
core_pkg.sv
ready_table.sv
map_table.sv
free_list.sv
rename_stage.sv
rename_tb.sv
